// File: compile.f
hdl/vmaAddrPkg.sv
hdl/vmaCtlPkg.sv
hdl/vmaControl.sv
hdl/vmaAdder.sv
hdl/vmaRegister.sv
hdl/pcHeldRegs.sv
hdl/adrBreak.sv
hdl/vmaDiagMux.sv
hdl/vmaUnit.sv
tests/vmaUnitTb.sv

// File: hdl/adrBreak.sv
module adrBreak (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              loadBrk,
  input  logic [vmaAddrPkg::DATA_W-1:0]     ad,
  input  logic [vmaAddrPkg::ADDR_W-1:0]     vma,
  output logic [vmaAddrPkg::ADDR_W-1:0]     adrBrk,
  output logic                              match
);

  // Set by the first break load, so a cleared register never matches
  logic armed;

  always_ff @(posedge clk) begin
    if (reset) begin
      adrBrk <= '0;
      armed  <= 1'b0;
    end else if (loadBrk) begin
      adrBrk <= ad[vmaAddrPkg::ADDR_W-1:0];
      armed  <= 1'b1;
    end
  end

  // Compare against the live VMA, all sections included
  assign match = armed & (adrBrk == vma);

endmodule

// File: hdl/pcHeldRegs.sv
module pcHeldRegs (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              loadPc,
  input  logic                              loadHeld,
  input  logic                              loadPrev,
  input  logic [vmaAddrPkg::ADDR_W-1:0]     vma,
  input  logic [vmaAddrPkg::DATA_W-1:0]     ad,
  output logic [vmaAddrPkg::ADDR_W-1:0]     pc,
  output logic [vmaAddrPkg::ADDR_W-1:0]     held,
  output logic [vmaAddrPkg::SECT_W-1:0]     prevSec,
  output logic                              pcSection0
);

  logic [vmaAddrPkg::SECT_W-1:0] adSection;

  // Section field of the external address
  assign adSection = ad[vmaAddrPkg::ADDR_W-1:vmaAddrPkg::OFS_W];

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (loadPc) begin
      pc <= vma;
    end
  end

  // VMA as it stood when the reference was held
  always_ff @(posedge clk) begin
    if (reset) begin
      held <= '0;
    end else if (loadHeld) begin
      held <= vma;
    end
  end

  // Previous context section
  always_ff @(posedge clk) begin
    if (reset) begin
      prevSec <= '0;
    end else if (loadPrev) begin
      prevSec <= adSection;
    end
  end

  assign pcSection0 = pc[vmaAddrPkg::ADDR_W-1:vmaAddrPkg::OFS_W] == '0;

endmodule

// File: hdl/vmaAdder.sv
module vmaAdder (
  input  vmaCtlPkg::vmaSrcT                 vmaSrc,
  input  logic [vmaAddrPkg::DATA_W-1:0]     ad,
  input  logic [vmaAddrPkg::MAGIC_W-1:0]    magic,
  input  logic [vmaAddrPkg::ADDR_W-1:0]     pc,
  input  logic [vmaAddrPkg::ADDR_W-1:0]     vma,
  output logic [vmaAddrPkg::ADDR_W-1:0]     vmaNext
);

  logic [vmaAddrPkg::OFS_W-1:0] pcMagicOfs;
  logic [vmaAddrPkg::OFS_W-1:0] vmaIncOfs;
  logic [vmaAddrPkg::OFS_W-1:0] magicExt;

  assign magicExt = vmaAddrPkg::OFS_W'(magic);

  // Offsets wrap within the section, no carry into the section field
  assign pcMagicOfs = pc[vmaAddrPkg::OFS_W-1:0] + magicExt;
  assign vmaIncOfs  = vma[vmaAddrPkg::OFS_W-1:0] + vmaAddrPkg::OFS_W'(1);

  always_comb begin
    case (vmaSrc)
      vmaCtlPkg::SRC_MAGIC: begin
        vmaNext = {pc[vmaAddrPkg::ADDR_W-1:vmaAddrPkg::OFS_W], pcMagicOfs};
      end
      vmaCtlPkg::SRC_INC: begin
        vmaNext = {vma[vmaAddrPkg::ADDR_W-1:vmaAddrPkg::OFS_W], vmaIncOfs};
      end
      default: begin
        vmaNext = ad[vmaAddrPkg::ADDR_W-1:0];
      end
    endcase
  end

endmodule

// File: hdl/vmaAddrPkg.sv
package vmaAddrPkg;

  // Section number plus in-section offset
  localparam int ADDR_W = 23;
  localparam int SECT_W = 5;
  localparam int OFS_W = 18;

  // Microcode magic field
  localparam int MAGIC_W = 6;

  // Full external data word
  localparam int DATA_W = 36;

  // Offsets below this reference the accumulators when local
  localparam logic [OFS_W-1:0] AC_LIMIT = 18'd16;

  // Width of the packed diagnostic flags word
  localparam int FLAGS_W = SECT_W + 3;

endpackage

// File: hdl/vmaControl.sv
module vmaControl (
  input  logic               clk,
  input  logic               reset,
  input  vmaCtlPkg::vmaOpT   op,
  output logic               loadVma,
  output logic               loadPc,
  output logic               loadHeld,
  output logic               loadPrev,
  output logic               loadBrk,
  output logic               extended,
  output vmaCtlPkg::vmaSrcT  vmaSrc
);

  logic setExt;
  logic clrExt;

  always_comb begin
    loadVma  = 1'b0;
    loadPc   = 1'b0;
    loadHeld = 1'b0;
    loadPrev = 1'b0;
    loadBrk  = 1'b0;
    setExt   = 1'b0;
    clrExt   = 1'b0;
    vmaSrc   = vmaCtlPkg::SRC_AD;
    case (op)
      vmaCtlPkg::OP_LOAD_AD: begin
        loadVma = 1'b1;
      end
      vmaCtlPkg::OP_PC_MAGIC: begin
        loadVma = 1'b1;
        vmaSrc  = vmaCtlPkg::SRC_MAGIC;
      end
      vmaCtlPkg::OP_INC: begin
        loadVma = 1'b1;
        vmaSrc  = vmaCtlPkg::SRC_INC;
      end
      vmaCtlPkg::OP_LOAD_PC:   loadPc = 1'b1;
      vmaCtlPkg::OP_LOAD_HELD: loadHeld = 1'b1;
      vmaCtlPkg::OP_LOAD_PREV: loadPrev = 1'b1;
      vmaCtlPkg::OP_LOAD_BRK:  loadBrk = 1'b1;
      vmaCtlPkg::OP_SET_EXT:   setExt = 1'b1;
      vmaCtlPkg::OP_CLR_EXT:   clrExt = 1'b1;
      default: begin
      end
    endcase
  end

  // Extended addressing mode
  always_ff @(posedge clk) begin
    if (reset) begin
      extended <= 1'b0;
    end else if (setExt) begin
      extended <= 1'b1;
    end else if (clrExt) begin
      extended <= 1'b0;
    end
  end

  // Microcode presents a defined opcode every cycle
  opDefined: assert property (
    @(posedge clk) disable iff (reset)
    !$isunknown(op) && (op <= vmaCtlPkg::OP_CLR_EXT)
  );

endmodule

// File: hdl/vmaCtlPkg.sv
package vmaCtlPkg;

  // Microcode operations on the VMA section
  typedef enum logic [3:0] {
    OP_NOP       = 4'd0,
    OP_LOAD_AD   = 4'd1,
    OP_PC_MAGIC  = 4'd2,
    OP_INC       = 4'd3,
    OP_LOAD_PC   = 4'd4,
    OP_LOAD_HELD = 4'd5,
    OP_LOAD_PREV = 4'd6,
    OP_LOAD_BRK  = 4'd7,
    OP_SET_EXT   = 4'd8,
    OP_CLR_EXT   = 4'd9
  } vmaOpT;

  // Next VMA source
  typedef enum logic [1:0] {
    SRC_AD    = 2'd0,
    SRC_MAGIC = 2'd1,
    SRC_INC   = 2'd2
  } vmaSrcT;

  // Diagnostic readback select
  typedef enum logic [2:0] {
    DIAG_VMA   = 3'd0,
    DIAG_PC    = 3'd1,
    DIAG_HELD  = 3'd2,
    DIAG_BRK   = 3'd3,
    DIAG_FLAGS = 3'd4
  } diagSelT;

endpackage

// File: hdl/vmaDiagMux.sv
module vmaDiagMux (
  input  logic                              readVma,
  input  vmaCtlPkg::diagSelT                diagSel,
  input  logic [vmaAddrPkg::ADDR_W-1:0]     vma,
  input  logic [vmaAddrPkg::ADDR_W-1:0]     pc,
  input  logic [vmaAddrPkg::ADDR_W-1:0]     held,
  input  logic [vmaAddrPkg::ADDR_W-1:0]     adrBrk,
  input  logic [vmaAddrPkg::SECT_W-1:0]     prevSec,
  input  logic                              vmaSection0,
  input  logic                              pcSection0,
  input  logic                              extended,
  output logic [vmaAddrPkg::DATA_W-1:0]     readData,
  output logic                              driving
);

  logic [vmaAddrPkg::DATA_W-1:0]  word;
  logic [vmaAddrPkg::FLAGS_W-1:0] flags;

  // Previous section above the three status bits
  assign flags = {prevSec, vmaSection0, pcSection0, extended};

  always_comb begin
    word = '0;
    case (diagSel)
      vmaCtlPkg::DIAG_VMA:   word = vmaAddrPkg::DATA_W'(vma);
      vmaCtlPkg::DIAG_PC:    word = vmaAddrPkg::DATA_W'(pc);
      vmaCtlPkg::DIAG_HELD:  word = vmaAddrPkg::DATA_W'(held);
      vmaCtlPkg::DIAG_BRK:   word = vmaAddrPkg::DATA_W'(adrBrk);
      vmaCtlPkg::DIAG_FLAGS: word = vmaAddrPkg::DATA_W'(flags);
      default:               word = '0;
    endcase
  end

  // Bus stays quiet unless the VMA is being read
  assign readData = readVma ? word : '0;
  assign driving  = readVma;

endmodule

// File: hdl/vmaRegister.sv
module vmaRegister (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              loadVma,
  input  logic                              extended,
  input  logic [vmaAddrPkg::ADDR_W-1:0]     vmaNext,
  output logic [vmaAddrPkg::ADDR_W-1:0]     vma,
  output logic                              vmaSection0,
  output logic                              acRef
);

  logic [vmaAddrPkg::SECT_W-1:0] section;
  logic [vmaAddrPkg::OFS_W-1:0]  offset;
  logic                          section01;
  logic                          isLocal;

  always_ff @(posedge clk) begin
    if (reset) begin
      vma <= '0;
    end else if (loadVma) begin
      vma <= vmaNext;
    end
  end

  assign section = vma[vmaAddrPkg::ADDR_W-1:vmaAddrPkg::OFS_W];
  assign offset  = vma[vmaAddrPkg::OFS_W-1:0];

  assign vmaSection0 = section == '0;

  // Section 0 or 1, low bit ignored
  assign section01 = section[vmaAddrPkg::SECT_W-1:1] == '0;

  // Unextended addressing is always local
  assign isLocal = ~extended | section01;
  assign acRef   = isLocal & (offset < vmaAddrPkg::AC_LIMIT);

  // A loaded address is fully known
  vmaNextKnown: assert property (
    @(posedge clk) disable iff (reset)
    loadVma |-> !$isunknown(vmaNext)
  );

endmodule

// File: hdl/vmaUnit.sv
module vmaUnit (
  input  logic                              clk,
  input  logic                              reset,
  input  vmaCtlPkg::vmaOpT                  op,
  input  logic [vmaAddrPkg::DATA_W-1:0]     ad,
  input  logic [vmaAddrPkg::MAGIC_W-1:0]    magic,
  input  logic                              readVma,
  input  vmaCtlPkg::diagSelT                diagSel,
  output logic [vmaAddrPkg::ADDR_W-1:0]     vma,
  output logic                              acRef,
  output logic                              match,
  output logic                              extended,
  output logic [vmaAddrPkg::DATA_W-1:0]     readData,
  output logic                              driving
);

  logic                          loadVma;
  logic                          loadPc;
  logic                          loadHeld;
  logic                          loadPrev;
  logic                          loadBrk;
  vmaCtlPkg::vmaSrcT             vmaSrc;
  logic [vmaAddrPkg::ADDR_W-1:0] vmaNext;
  logic [vmaAddrPkg::ADDR_W-1:0] pc;
  logic [vmaAddrPkg::ADDR_W-1:0] held;
  logic [vmaAddrPkg::ADDR_W-1:0] adrBrk;
  logic [vmaAddrPkg::SECT_W-1:0] prevSec;
  logic                          vmaSection0;
  logic                          pcSection0;

  vmaControl control (
    .clk(clk), .reset(reset), .op(op),
    .loadVma(loadVma), .loadPc(loadPc), .loadHeld(loadHeld),
    .loadPrev(loadPrev), .loadBrk(loadBrk),
    .extended(extended), .vmaSrc(vmaSrc)
  );

  vmaAdder adder (
    .vmaSrc(vmaSrc), .ad(ad), .magic(magic),
    .pc(pc), .vma(vma), .vmaNext(vmaNext)
  );

  vmaRegister vmaReg (
    .clk(clk), .reset(reset), .loadVma(loadVma), .extended(extended),
    .vmaNext(vmaNext), .vma(vma), .vmaSection0(vmaSection0), .acRef(acRef)
  );

  pcHeldRegs pcHeld (
    .clk(clk), .reset(reset),
    .loadPc(loadPc), .loadHeld(loadHeld), .loadPrev(loadPrev),
    .vma(vma), .ad(ad),
    .pc(pc), .held(held), .prevSec(prevSec), .pcSection0(pcSection0)
  );

  adrBreak brk (
    .clk(clk), .reset(reset), .loadBrk(loadBrk),
    .ad(ad), .vma(vma), .adrBrk(adrBrk), .match(match)
  );

  vmaDiagMux diag (
    .readVma(readVma), .diagSel(diagSel),
    .vma(vma), .pc(pc), .held(held), .adrBrk(adrBrk), .prevSec(prevSec),
    .vmaSection0(vmaSection0), .pcSection0(pcSection0), .extended(extended),
    .readData(readData), .driving(driving)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f compile.f --top-module vmaUnitTb -Mdir obj_dir &&
./obj_dir/VvmaUnitTb | tee /dev/stderr | grep -x "RESULT: PASS" > /dev/null ||
exit 1

// File: tests/vmaUnitTb.sv
module vmaUnitTb;

  localparam int RESET_CYCLES = 2;
  localparam int DIRECTED_CYCLES = 80;
  localparam int RANDOM_CYCLES = 400;
  localparam int TIMEOUT = (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * 10 + 100;

  logic                              clk;
  logic                              reset;
  vmaCtlPkg::vmaOpT                  op;
  logic [vmaAddrPkg::DATA_W-1:0]     ad;
  logic [vmaAddrPkg::MAGIC_W-1:0]    magic;
  logic                              readVma;
  vmaCtlPkg::diagSelT                diagSel;
  logic [vmaAddrPkg::ADDR_W-1:0]     vma;
  logic                              acRef;
  logic                              match;
  logic                              extended;
  logic [vmaAddrPkg::DATA_W-1:0]     readData;
  logic                              driving;

  // Reference model state
  logic [vmaAddrPkg::ADDR_W-1:0] mVma;
  logic [vmaAddrPkg::ADDR_W-1:0] mPc;
  logic [vmaAddrPkg::ADDR_W-1:0] mHeld;
  logic [vmaAddrPkg::ADDR_W-1:0] mBrk;
  logic [vmaAddrPkg::SECT_W-1:0] mPrev;
  logic                          mArmed;
  logic                          mExt;

  int     errors;
  int     checks;
  integer seed;

  vmaUnit vmaUnit_i (
    .clk(clk), .reset(reset), .op(op), .ad(ad), .magic(magic),
    .readVma(readVma), .diagSel(diagSel),
    .vma(vma), .acRef(acRef), .match(match), .extended(extended),
    .readData(readData), .driving(driving)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [vmaAddrPkg::SECT_W-1:0] sectOf(
    input logic [vmaAddrPkg::ADDR_W-1:0] a
  );
    return a[vmaAddrPkg::ADDR_W-1:vmaAddrPkg::OFS_W];
  endfunction

  function automatic logic [vmaAddrPkg::OFS_W-1:0] ofsOf(
    input logic [vmaAddrPkg::ADDR_W-1:0] a
  );
    return a[vmaAddrPkg::OFS_W-1:0];
  endfunction

  function automatic logic [vmaAddrPkg::DATA_W-1:0] mkAd(
    input logic [vmaAddrPkg::SECT_W-1:0] s,
    input logic [vmaAddrPkg::OFS_W-1:0] o
  );
    return vmaAddrPkg::DATA_W'({s, o});
  endfunction

  function void resetModel();
    mVma = '0;
    mPc = '0;
    mHeld = '0;
    mBrk = '0;
    mPrev = '0;
    mArmed = 1'b0;
    mExt = 1'b0;
  endfunction

  // Advance the model by one opcode
  function void refStep(
    input vmaCtlPkg::vmaOpT o,
    input logic [vmaAddrPkg::DATA_W-1:0] a,
    input logic [vmaAddrPkg::MAGIC_W-1:0] m
  );
    logic [vmaAddrPkg::OFS_W-1:0] sum;
    case (o)
      vmaCtlPkg::OP_LOAD_AD: mVma = a[vmaAddrPkg::ADDR_W-1:0];
      vmaCtlPkg::OP_PC_MAGIC: begin
        sum = ofsOf(mPc) + vmaAddrPkg::OFS_W'(m);
        mVma = {sectOf(mPc), sum};
      end
      vmaCtlPkg::OP_INC: begin
        sum = ofsOf(mVma) + 18'd1;
        mVma = {sectOf(mVma), sum};
      end
      vmaCtlPkg::OP_LOAD_PC:   mPc = mVma;
      vmaCtlPkg::OP_LOAD_HELD: mHeld = mVma;
      vmaCtlPkg::OP_LOAD_PREV: mPrev = sectOf(a[vmaAddrPkg::ADDR_W-1:0]);
      vmaCtlPkg::OP_LOAD_BRK: begin
        mBrk = a[vmaAddrPkg::ADDR_W-1:0];
        mArmed = 1'b1;
      end
      vmaCtlPkg::OP_SET_EXT: mExt = 1'b1;
      vmaCtlPkg::OP_CLR_EXT: mExt = 1'b0;
      default: begin
      end
    endcase
  endfunction

  function automatic logic expAcRef();
    logic isLocal;
    isLocal = !mExt || (sectOf(mVma) <= 5'd1);
    return isLocal && (ofsOf(mVma) < vmaAddrPkg::AC_LIMIT);
  endfunction

  function automatic logic [vmaAddrPkg::DATA_W-1:0] expRead(
    input logic rv,
    input vmaCtlPkg::diagSelT sel
  );
    logic [7:0] flags;
    flags = {mPrev, sectOf(mVma) == 5'd0, sectOf(mPc) == 5'd0, mExt};
    if (!rv) begin
      return '0;
    end
    case (sel)
      vmaCtlPkg::DIAG_VMA:   return vmaAddrPkg::DATA_W'(mVma);
      vmaCtlPkg::DIAG_PC:    return vmaAddrPkg::DATA_W'(mPc);
      vmaCtlPkg::DIAG_HELD:  return vmaAddrPkg::DATA_W'(mHeld);
      vmaCtlPkg::DIAG_BRK:   return vmaAddrPkg::DATA_W'(mBrk);
      vmaCtlPkg::DIAG_FLAGS: return vmaAddrPkg::DATA_W'(flags);
      default:               return '0;
    endcase
  endfunction

  task automatic checkOutputs();
    logic [vmaAddrPkg::DATA_W-1:0] expData;
    expData = expRead(readVma, diagSel);
    checks = checks + 1;
    assert (vma === mVma) else begin
      errors = errors + 1;
      $display("error at %0t: vma %h, expected %h", $time, vma, mVma);
    end
    assert (acRef === expAcRef()) else begin
      errors = errors + 1;
      $display("error at %0t: acRef %b, expected %b", $time, acRef, expAcRef());
    end
    assert (match === (mArmed && (mBrk == mVma))) else begin
      errors = errors + 1;
      $display("error at %0t: match %b with brk %h and vma %h", $time, match, mBrk, mVma);
    end
    assert (extended === mExt) else begin
      errors = errors + 1;
      $display("error at %0t: extended %b, expected %b", $time, extended, mExt);
    end
    assert (readData === expData) else begin
      errors = errors + 1;
      $display("error at %0t: readData %h, expected %h (sel %0d)", $time, readData,
               expData, diagSel);
    end
    assert (driving === readVma) else begin
      errors = errors + 1;
      $display("error at %0t: driving %b, expected %b", $time, driving, readVma);
    end
  endtask

  // Outputs still show the state left by the previous edge
  always @(posedge clk) begin
    if (reset) begin
      resetModel();
    end else begin
      checkOutputs();
      refStep(op, ad, magic);
    end
  end

  task automatic applyOp(
    input vmaCtlPkg::vmaOpT o,
    input logic [vmaAddrPkg::DATA_W-1:0] a,
    input logic [vmaAddrPkg::MAGIC_W-1:0] m,
    input logic rv,
    input vmaCtlPkg::diagSelT sel
  );
    @(negedge clk);
    op = o;
    ad = a;
    magic = m;
    readVma = rv;
    diagSel = sel;
  endtask

  task automatic readAll();
    applyOp(vmaCtlPkg::OP_NOP, '0, '0, 1'b1, vmaCtlPkg::DIAG_VMA);
    applyOp(vmaCtlPkg::OP_NOP, '0, '0, 1'b1, vmaCtlPkg::DIAG_PC);
    applyOp(vmaCtlPkg::OP_NOP, '0, '0, 1'b1, vmaCtlPkg::DIAG_HELD);
    applyOp(vmaCtlPkg::OP_NOP, '0, '0, 1'b1, vmaCtlPkg::DIAG_BRK);
    applyOp(vmaCtlPkg::OP_NOP, '0, '0, 1'b1, vmaCtlPkg::DIAG_FLAGS);
  endtask

  task automatic randomStream(input int cycles);
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [vmaAddrPkg::DATA_W-1:0] a;
    int opIdx;
    int selIdx;
    for (int i = 0; i < cycles; i++) begin
      r1 = $random(seed);
      r2 = $random(seed);
      r3 = $random(seed);
      opIdx = int'(r3 % 32'd10);
      selIdx = int'(r2[14:12]);
      if (selIdx > 4) begin
        selIdx = selIdx - 3;
      end
      // Small addresses in low sections so breaks and AC refs show up
      if (r2[31:30] == 2'b00) begin
        a = mkAd({3'd0, r1[1:0]}, {13'd0, r1[6:2]});
      end else begin
        a = {r2[3:0], r1};
      end
      applyOp(vmaCtlPkg::vmaOpT'(opIdx[3:0]), a, r2[9:4], r2[10],
              vmaCtlPkg::diagSelT'(selIdx[2:0]));
    end
  endtask

  initial begin
    errors = 0;
    checks = 0;
    seed = 32'h4ecb_0292;
    reset = 1'b1;
    op = vmaCtlPkg::OP_NOP;
    ad = '0;
    magic = '0;
    readVma = 1'b0;
    diagSel = vmaCtlPkg::DIAG_VMA;
    resetModel();
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;

    readAll();

    // VMA sources, offset wraps inside the section
    applyOp(vmaCtlPkg::OP_LOAD_AD, mkAd(5'd3, 18'h3fffe), '0, 1'b1, vmaCtlPkg::DIAG_VMA);
    applyOp(vmaCtlPkg::OP_INC, '0, '0, 1'b1, vmaCtlPkg::DIAG_VMA);
    applyOp(vmaCtlPkg::OP_INC, '0, '0, 1'b1, vmaCtlPkg::DIAG_VMA);
    applyOp(vmaCtlPkg::OP_LOAD_AD, mkAd(5'd2, 18'h3fffc), '0, 1'b0, vmaCtlPkg::DIAG_VMA);
    applyOp(vmaCtlPkg::OP_LOAD_PC, '0, '0, 1'b1, vmaCtlPkg::DIAG_PC);
    applyOp(vmaCtlPkg::OP_PC_MAGIC, '0, 6'h3f, 1'b1, vmaCtlPkg::DIAG_VMA);
    applyOp(vmaCtlPkg::OP_PC_MAGIC, '0, 6'h01, 1'b1, vmaCtlPkg::DIAG_VMA);

    // Captured registers through every select
    applyOp(vmaCtlPkg::OP_LOAD_HELD, '0, '0, 1'b0, vmaCtlPkg::DIAG_VMA);
    applyOp(vmaCtlPkg::OP_LOAD_PREV, mkAd(5'h15, 18'h1234), '0, 1'b0, vmaCtlPkg::DIAG_VMA);
    readAll();
    applyOp(vmaCtlPkg::OP_LOAD_AD, mkAd(5'd0, 18'h00100), '0, 1'b0, vmaCtlPkg::DIAG_VMA);
    applyOp(vmaCtlPkg::OP_LOAD_PC, '0, '0, 1'b0, vmaCtlPkg::DIAG_VMA);
    applyOp(vmaCtlPkg::OP_SET_EXT, '0, '0, 1'b0, vmaCtlPkg::DIAG_VMA);
    readAll();

    // Address break
    applyOp(vmaCtlPkg::OP_LOAD_BRK, mkAd(5'd1, 18'h00005), '0, 1'b1, vmaCtlPkg::DIAG_BRK);
    applyOp(vmaCtlPkg::OP_LOAD_AD, mkAd(5'd1, 18'h00004), '0, 1'b0, vmaCtlPkg::DIAG_VMA);
    applyOp(vmaCtlPkg::OP_INC, '0, '0, 1'b0, vmaCtlPkg::DIAG_VMA);
    applyOp(vmaCtlPkg::OP_INC, '0, '0, 1'b0, vmaCtlPkg::DIAG_VMA);

    // Locality rule for AC references
    applyOp(vmaCtlPkg::OP_CLR_EXT, '0, '0, 1'b0, vmaCtlPkg::DIAG_FLAGS);
    applyOp(vmaCtlPkg::OP_LOAD_AD, mkAd(5'd7, 18'h00003), '0, 1'b0, vmaCtlPkg::DIAG_VMA);
    applyOp(vmaCtlPkg::OP_SET_EXT, '0, '0, 1'b1, vmaCtlPkg::DIAG_FLAGS);
    applyOp(vmaCtlPkg::OP_LOAD_AD, mkAd(5'd1, 18'h0000f), '0, 1'b0, vmaCtlPkg::DIAG_VMA);
    applyOp(vmaCtlPkg::OP_LOAD_AD, mkAd(5'd0, 18'h00010), '0, 1'b0, vmaCtlPkg::DIAG_VMA);
    applyOp(vmaCtlPkg::OP_LOAD_AD, mkAd(5'd0, 18'h00002), '0, 1'b0, vmaCtlPkg::DIAG_VMA);
    applyOp(vmaCtlPkg::OP_LOAD_AD, mkAd(5'd2, 18'h00002), '0, 1'b0, vmaCtlPkg::DIAG_VMA);
    applyOp(vmaCtlPkg::OP_CLR_EXT, '0, '0, 1'b0, vmaCtlPkg::DIAG_FLAGS);

    // Bus released while not reading
    applyOp(vmaCtlPkg::OP_NOP, '0, '0, 1'b0, vmaCtlPkg::DIAG_PC);
    applyOp(vmaCtlPkg::OP_NOP, '0, '0, 1'b0, vmaCtlPkg::DIAG_FLAGS);

    randomStream(RANDOM_CYCLES);

    applyOp(vmaCtlPkg::OP_NOP, '0, '0, 1'b1, vmaCtlPkg::DIAG_VMA);
    applyOp(vmaCtlPkg::OP_NOP, '0, '0, 1'b0, vmaCtlPkg::DIAG_VMA);
    @(posedge clk);
    #1;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("timeout: the run did not finish within %0d time units", TIMEOUT);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
